//--- common/decap_pkg.sv
// Shared widths, ring counts and record types for the RCI decapsulation lookup.
// Every RTL file and the testbench refer to these by decap_pkg::name.
`default_nettype none

package decap_pkg;

        localparam int RING_W = 64;
        localparam int KEY_W = 128;
        localparam int PAYLOAD_W = 32;
        localparam int HASH_W = 10;
        localparam int VALUE_ADDR_W = 12;
        localparam int ENTRY_W = 1 + VALUE_ADDR_W + HASH_W;    // Valid, value address, tag
        localparam int BUCKET_W = 2 * ENTRY_W;

        localparam int WORDS_PER_SEG = 5;
        localparam int SEGS_PER_FRAME = 6;
        localparam int WARMUP_FRAMES = 16;
        localparam int SEG_IDX_W = 3;
        localparam int WORD_IDX_W = 3;
        localparam int FRAME_W = 5;
        localparam int PROBE_GAP = 5;
        localparam int FIFO_DEPTH_LOG = 3;

        localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(WORDS_PER_SEG - 1);
        localparam logic [SEG_IDX_W-1:0] LAST_SEG = SEG_IDX_W'(SEGS_PER_FRAME - 1);
        localparam logic [FRAME_W-1:0] WARMUP_CNT = FRAME_W'(WARMUP_FRAMES);

        typedef struct packed {
                logic [SEG_IDX_W-1:0] seg;
                logic [KEY_W-1:0] key;
        } key_rec_t;

        typedef struct packed {
                logic [KEY_W-1:0] key;
                logic [PAYLOAD_W-1:0] payload;
        } value_word_t;

        typedef struct packed {
                logic hit;
                logic [SEG_IDX_W-1:0] seg;
                logic [PAYLOAD_W-1:0] payload;
        } result_t;

        typedef struct packed {
                logic [BUCKET_W-1:0] ht1;
                logic [BUCKET_W-1:0] ht0;     // Entry 0 sits in the low ENTRY_W bits
        } bucket_pair_t;

        // ####################
        // Hash fold. The key is cut into HASH_W-bit slices from bit 0 upward, the last
        // slice is zero-padded, and all slices are XORed together. Hash 1 applies the
        // same fold to the bit-reversed key.
        // ####################
        localparam int HASH_SLICES = (KEY_W + HASH_W - 1) / HASH_W;

        function automatic logic [HASH_W-1:0] fold_hash(input logic [KEY_W-1:0] key);
                logic [HASH_SLICES*HASH_W-1:0] padded;
                logic [HASH_W-1:0] h;
                padded = '0;
                padded[KEY_W-1:0] = key;
                h = '0;
                for (int i = 0; i < HASH_SLICES; i++)
                        h = h ^ padded[i*HASH_W +: HASH_W];
                return h;
        endfunction

endpackage

`default_nettype wire

//--- design/sync_fifo.sv
// First-word-fall-through FIFO on a register array.
// The head entry is on dout whenever empty is low.
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
        parameter int WIDTH = 8,
        parameter int DEPTH_LOG = 3
) (
        input wire clk,
        input wire rst,
        input wire wr,
        input wire [WIDTH-1:0] din,
        input wire rd,
        output logic [WIDTH-1:0] dout,
        output logic empty
);

        logic [WIDTH-1:0] mem [2**DEPTH_LOG];
        logic [DEPTH_LOG:0] wr_ptr;     // Extra bit tells full from empty
        logic [DEPTH_LOG:0] rd_ptr;

        assign empty = wr_ptr == rd_ptr;
        assign dout = mem[rd_ptr[DEPTH_LOG-1:0]];

        always_ff @(posedge clk) begin
                if (wr)
                        mem[wr_ptr[DEPTH_LOG-1:0]] <= din;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (wr)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (rd && !empty)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- design/ring_capture.sv
// Input side of the lookup. Tracks word and segment position on the input ring,
// waits out the warm-up frames and then queues one key record per segment.
`timescale 1ns/1ps
`default_nettype none

module ring_capture (
        input wire clk,
        input wire rst,
        input wire [decap_pkg::RING_W-1:0] ring_in_data,
        input wire ring_in_sof,
        input wire ring_in_sos,
        output logic key_wr,
        output decap_pkg::key_rec_t key_rec
);

        logic [decap_pkg::RING_W-1:0] data_d1;
        logic [decap_pkg::RING_W-1:0] data_d2;
        logic sof_d1;
        logic sos_d1;
        logic [decap_pkg::WORD_IDX_W-1:0] word_cnt;    // Position of data_d2
        logic [decap_pkg::SEG_IDX_W-1:0] seg_cnt;
        logic [decap_pkg::FRAME_W-1:0] frame_cnt;
        logic ready;
        logic last_word;
        logic last_seg;
        logic [decap_pkg::KEY_W-1:0] key_r;

        assign last_word = word_cnt == decap_pkg::LAST_WORD;
        assign last_seg = seg_cnt == decap_pkg::LAST_SEG;

        assign key_wr = ready && word_cnt == 3'd2;     // Key is complete after word 1
        assign key_rec = '{seg: seg_cnt, key: key_r};

        always_ff @(posedge clk) begin
                data_d1 <= ring_in_data;
                data_d2 <= data_d1;
                if (word_cnt == 3'd0)
                        key_r[decap_pkg::RING_W-1:0] <= data_d2;
                if (word_cnt == 3'd1)
                        key_r[decap_pkg::KEY_W-1:decap_pkg::RING_W] <= data_d2;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        sof_d1 <= 1'b0;
                        sos_d1 <= 1'b0;
                        word_cnt <= '0;
                        seg_cnt <= '0;
                        frame_cnt <= '0;
                        ready <= 1'b0;
                end else begin
                        sof_d1 <= ring_in_sof;
                        sos_d1 <= ring_in_sos;
                        word_cnt <= (sos_d1 || last_word) ? '0 : word_cnt + 1'b1;
                        if (sof_d1)
                                seg_cnt <= '0;
                        else if (last_word)
                                seg_cnt <= last_seg ? '0 : seg_cnt + 1'b1;
                        if (sof_d1 && frame_cnt != decap_pkg::WARMUP_CNT)
                                frame_cnt <= frame_cnt + 1'b1;
                        if (sof_d1 && frame_cnt == decap_pkg::WARMUP_CNT)
                                ready <= 1'b1;         // First frame after warm-up
                end
        end

endmodule

`default_nettype wire

//--- lookup/key_hash.sv
// Registered hash of a key for both hash tables.
// hash0 folds the key itself, hash1 folds the bit-reversed key.
`timescale 1ns/1ps
`default_nettype none

module key_hash (
        input wire clk,
        input wire [decap_pkg::KEY_W-1:0] key,
        output logic [decap_pkg::HASH_W-1:0] hash0,
        output logic [decap_pkg::HASH_W-1:0] hash1
);

        logic [decap_pkg::KEY_W-1:0] key_rev;

        assign key_rev = {<<{key}};

        always_ff @(posedge clk) begin
                hash0 <= decap_pkg::fold_hash(key);
                hash1 <= decap_pkg::fold_hash(key_rev);
        end

endmodule

`default_nettype wire

//--- lookup/bucket_probe.sv
// Front half of a lookup. Pops keys at most once every PROBE_GAP cycles,
// reads both hash-table buckets, then issues the four value-table reads.
`timescale 1ns/1ps
`default_nettype none

module bucket_probe (
        input wire clk,
        input wire rst,
        input wire key_empty,
        output logic key_rd,
        input var decap_pkg::key_rec_t key_rec,
        output logic ht_rd,
        output logic [decap_pkg::HASH_W-1:0] ht0_addr,
        output logic [decap_pkg::HASH_W-1:0] ht1_addr,
        input wire ht_ack,
        input var decap_pkg::bucket_pair_t ht_rdata,
        output logic val_rd,
        output logic [decap_pkg::VALUE_ADDR_W-1:0] val_addr,
        output logic valid_wr,
        output logic [3:0] entry_valid
);

        logic [decap_pkg::PROBE_GAP-2:0] pop_hist;     // Bit 0 is the pop one cycle ago
        logic [decap_pkg::HASH_W-1:0] hash0;
        logic [decap_pkg::HASH_W-1:0] hash1;
        logic [3:0][decap_pkg::ENTRY_W-1:0] entries;
        logic [3:0] ack_d;
        logic [1:0] ent_idx;

        assign key_rd = !key_empty && !(|pop_hist);

        key_hash u_key_hash (
                .clk(clk),
                .key(key_rec.key),
                .hash0(hash0),
                .hash1(hash1)
        );

        // ####################
        // Value reads, one per entry on the four cycles after the buckets land
        // ####################
        assign val_rd = |ack_d;
        assign val_addr = entries[ent_idx][decap_pkg::ENTRY_W-2 -: decap_pkg::VALUE_ADDR_W];
        assign valid_wr = ack_d[0];

        always_comb begin
                for (int i = 0; i < 4; i++)
                        entry_valid[i] = entries[i][decap_pkg::ENTRY_W-1];
        end

        always_ff @(posedge clk) begin
                ht0_addr <= hash0;
                ht1_addr <= hash1;
                if (ht_ack)
                        entries <= {ht_rdata.ht1, ht_rdata.ht0};
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        pop_hist <= '0;
                        ht_rd <= 1'b0;
                        ack_d <= '0;
                        ent_idx <= '0;
                end else begin
                        pop_hist <= {pop_hist[decap_pkg::PROBE_GAP-3:0], key_rd};
                        ht_rd <= pop_hist[0];  // Hashes are ready one cycle after the pop
                        ack_d <= {ack_d[2:0], ht_ack};
                        if (val_rd)
                                ent_idx <= ent_idx + 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- lookup/entry_match.sv
// Back half of a lookup. Compares each value-table word against the in-flight
// key and reports one result after the fourth value acknowledge.
`timescale 1ns/1ps
`default_nettype none

module entry_match (
        input wire clk,
        input wire rst,
        input wire val_ack,
        input var decap_pkg::value_word_t val_rdata,
        input var decap_pkg::key_rec_t flight_key,
        input wire [3:0] entry_valid,
        output logic done,
        output decap_pkg::result_t result
);

        logic ack_d1;
        decap_pkg::value_word_t word_d1;
        logic [1:0] ack_cnt;           // Entry index of word_d1
        logic match;
        logic hit_r;
        logic [decap_pkg::PAYLOAD_W-1:0] pay_r;

        assign match = ack_d1 && entry_valid[ack_cnt] && word_d1.key == flight_key.key;
        assign result = '{hit: hit_r, seg: flight_key.seg, payload: pay_r};

        always_ff @(posedge clk) begin
                word_d1 <= val_rdata;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        ack_d1 <= 1'b0;
                        ack_cnt <= '0;
                        done <= 1'b0;
                        hit_r <= 1'b0;
                        pay_r <= '0;
                end else begin
                        ack_d1 <= val_ack;
                        if (ack_d1)
                                ack_cnt <= ack_cnt + 1'b1;
                        done <= ack_d1 && ack_cnt == 2'd3;
                        if (done) begin
                                hit_r <= 1'b0;
                                pay_r <= '0;
                        end else if (match) begin
                                hit_r <= 1'b1;
                                pay_r <= word_d1.payload;      // Later entries win
                        end
                end
        end

endmodule

`default_nettype wire

//--- design/ring_emit.sv
// Output side of the lookup. Drives a free-running output ring and fills
// word 0 of each segment from the pending result queue, in segment order.
`timescale 1ns/1ps
`default_nettype none

module ring_emit (
        input wire clk,
        input wire rst,
        input wire res_wr,
        input var decap_pkg::result_t res,
        output logic [decap_pkg::RING_W-1:0] ring_out_data,
        output logic ring_out_sof,
        output logic ring_out_sos
);

        logic [decap_pkg::WORD_IDX_W-1:0] word_cnt;
        logic [decap_pkg::SEG_IDX_W-1:0] seg_cnt;
        logic [decap_pkg::SEG_IDX_W-1:0] next_seg;
        logic last_word;
        logic last_seg;
        logic enable;
        logic pend_rd;
        logic pend_empty;
        decap_pkg::result_t head;

        assign last_word = word_cnt == decap_pkg::LAST_WORD;
        assign last_seg = seg_cnt == decap_pkg::LAST_SEG;
        assign next_seg = !last_word ? seg_cnt : (last_seg ? '0 : seg_cnt + 1'b1);
        assign pend_rd = enable && last_word;          // Head was used by this segment

        sync_fifo #(
                .WIDTH($bits(decap_pkg::result_t)),
                .DEPTH_LOG(decap_pkg::FIFO_DEPTH_LOG)
        ) u_pending_fifo (
                .clk(clk),
                .rst(rst),
                .wr(res_wr),
                .din(res),
                .rd(pend_rd),
                .dout(head),
                .empty(pend_empty)
        );

        always_ff @(posedge clk) begin
                if (rst) begin
                        word_cnt <= '0;
                        seg_cnt <= '0;
                        enable <= 1'b0;
                        ring_out_data <= '0;
                        ring_out_sof <= 1'b0;
                        ring_out_sos <= 1'b0;
                end else begin
                        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                        seg_cnt <= next_seg;
                        if (last_word && !pend_empty && head.seg == next_seg)
                                enable <= 1'b1;        // Stays set from the first match
                        ring_out_sos <= last_word;
                        ring_out_sof <= last_word && last_seg;
                        if (enable && word_cnt == '0)
                                ring_out_data <= {head.hit,
                                        {(decap_pkg::RING_W-1-decap_pkg::PAYLOAD_W){1'b0}},
                                        head.payload};
                        else
                                ring_out_data <= '0;
                end
        end

endmodule

`default_nettype wire

//--- design/decap_lookup.sv
// Top level of the RCI lookup. Keys from the input ring pass through the key,
// in-flight and valid queues around the two lookup stages to the output ring.
`timescale 1ns/1ps
`default_nettype none

module decap_lookup (
        input wire clk,
        input wire rst,
        input wire [decap_pkg::RING_W-1:0] ring_in_data,
        input wire ring_in_sof,
        input wire ring_in_sos,
        output logic [decap_pkg::RING_W-1:0] ring_out_data,
        output logic ring_out_sof,
        output logic ring_out_sos,
        output logic ht_rd,
        output logic [decap_pkg::HASH_W-1:0] ht0_addr,
        output logic [decap_pkg::HASH_W-1:0] ht1_addr,
        input wire ht_ack,
        input var decap_pkg::bucket_pair_t ht_rdata,
        output logic val_rd,
        output logic [decap_pkg::VALUE_ADDR_W-1:0] val_addr,
        input wire val_ack,
        input var decap_pkg::value_word_t val_rdata
);

        localparam int REC_W = $bits(decap_pkg::key_rec_t);

        logic key_wr;
        logic key_rd;
        logic key_empty;
        decap_pkg::key_rec_t key_in;
        decap_pkg::key_rec_t key_head;
        decap_pkg::key_rec_t flight_key;
        logic valid_wr;
        logic [3:0] entry_valid;
        logic [3:0] valid_head;
        logic done;
        decap_pkg::result_t result;

        ring_capture u_ring_capture (
                .clk(clk), .rst(rst),
                .ring_in_data(ring_in_data), .ring_in_sof(ring_in_sof),
                .ring_in_sos(ring_in_sos),
                .key_wr(key_wr), .key_rec(key_in)
        );

        sync_fifo #(.WIDTH(REC_W), .DEPTH_LOG(decap_pkg::FIFO_DEPTH_LOG)) u_key_fifo (
                .clk(clk), .rst(rst), .wr(key_wr), .din(key_in),
                .rd(key_rd), .dout(key_head), .empty(key_empty)
        );

        // Each popped key waits here until its result is built
        sync_fifo #(.WIDTH(REC_W), .DEPTH_LOG(decap_pkg::FIFO_DEPTH_LOG)) u_flight_fifo (
                .clk(clk), .rst(rst), .wr(key_rd), .din(key_head),
                .rd(done), .dout(flight_key), .empty()
        );

        sync_fifo #(.WIDTH(4), .DEPTH_LOG(decap_pkg::FIFO_DEPTH_LOG)) u_valid_fifo (
                .clk(clk), .rst(rst), .wr(valid_wr), .din(entry_valid),
                .rd(done), .dout(valid_head), .empty()
        );

        bucket_probe u_bucket_probe (
                .clk(clk), .rst(rst),
                .key_empty(key_empty), .key_rd(key_rd), .key_rec(key_head),
                .ht_rd(ht_rd), .ht0_addr(ht0_addr), .ht1_addr(ht1_addr),
                .ht_ack(ht_ack), .ht_rdata(ht_rdata),
                .val_rd(val_rd), .val_addr(val_addr),
                .valid_wr(valid_wr), .entry_valid(entry_valid)
        );

        entry_match u_entry_match (
                .clk(clk), .rst(rst),
                .val_ack(val_ack), .val_rdata(val_rdata),
                .flight_key(flight_key), .entry_valid(valid_head),
                .done(done), .result(result)
        );

        ring_emit u_ring_emit (
                .clk(clk), .rst(rst),
                .res_wr(done), .res(result),
                .ring_out_data(ring_out_data), .ring_out_sof(ring_out_sof),
                .ring_out_sos(ring_out_sos)
        );

endmodule

`default_nettype wire

//--- sim/table_model.sv
// Behavioral model of the two hash tables and the value table.
// The testbench fills the arrays before the run. Replies come back in request
// order, 3 cycles after ht_rd and 2 cycles after val_rd.
`timescale 1ns/1ps
`default_nettype none

module table_model (
        input wire clk,
        input wire rst,
        input wire ht_rd,
        input wire [decap_pkg::HASH_W-1:0] ht0_addr,
        input wire [decap_pkg::HASH_W-1:0] ht1_addr,
        output logic ht_ack,
        output decap_pkg::bucket_pair_t ht_rdata,
        input wire val_rd,
        input wire [decap_pkg::VALUE_ADDR_W-1:0] val_addr,
        output logic val_ack,
        output decap_pkg::value_word_t val_rdata
);

        logic [decap_pkg::BUCKET_W-1:0] ht0_mem [2**decap_pkg::HASH_W];
        logic [decap_pkg::BUCKET_W-1:0] ht1_mem [2**decap_pkg::HASH_W];
        decap_pkg::value_word_t val_mem [2**decap_pkg::VALUE_ADDR_W];

        logic [1:0] ht_pipe;
        logic [decap_pkg::HASH_W-1:0] a0_pipe [2];
        logic [decap_pkg::HASH_W-1:0] a1_pipe [2];
        logic val_pipe;
        logic [decap_pkg::VALUE_ADDR_W-1:0] va_pipe;

        always_ff @(posedge clk) begin
                a0_pipe[0] <= ht0_addr;
                a0_pipe[1] <= a0_pipe[0];
                a1_pipe[0] <= ht1_addr;
                a1_pipe[1] <= a1_pipe[0];
                ht_rdata <= '{ht1: ht1_mem[a1_pipe[1]], ht0: ht0_mem[a0_pipe[1]]};
                va_pipe <= val_addr;
                val_rdata <= val_mem[va_pipe];
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        ht_pipe <= '0;
                        ht_ack <= 1'b0;
                        val_pipe <= 1'b0;
                        val_ack <= 1'b0;
                end else begin
                        ht_pipe <= {ht_pipe[0], ht_rd};
                        ht_ack <= ht_pipe[1];  // Third cycle after the request
                        val_pipe <= val_rd;
                        val_ack <= val_pipe;
                end
        end

endmodule

`default_nettype wire

//--- sim/decap_tb.sv
// Testbench for the RCI lookup. Runs the input ring through warm-up and four
// frames of keys, then checks each output segment against a reference lookup.
`timescale 1ns/1ps
`default_nettype none

module decap_tb;

        localparam int NUM_KEYS = 4 * decap_pkg::SEGS_PER_FRAME;
        localparam int SEG_CYC = decap_pkg::WORDS_PER_SEG;
        localparam int FRAME_CYC = SEG_CYC * decap_pkg::SEGS_PER_FRAME;
        localparam int TIMEOUT_CYC = 30 * FRAME_CYC;

        logic clk;
        logic rst;
        logic [decap_pkg::RING_W-1:0] ring_in_data;
        logic ring_in_sof;
        logic ring_in_sos;
        logic [decap_pkg::RING_W-1:0] ring_out_data;
        logic ring_out_sof;
        logic ring_out_sos;
        logic ht_rd;
        logic [decap_pkg::HASH_W-1:0] ht0_addr;
        logic [decap_pkg::HASH_W-1:0] ht1_addr;
        logic ht_ack;
        decap_pkg::bucket_pair_t ht_rdata;
        logic val_rd;
        logic [decap_pkg::VALUE_ADDR_W-1:0] val_addr;
        logic val_ack;
        decap_pkg::value_word_t val_rdata;

        logic [decap_pkg::KEY_W-1:0] keys [NUM_KEYS];
        integer seed;
        bit warmup;
        bit seen_sos;
        bit seen_sof;
        bit started;
        int cycles;
        int last_ht;
        int since_sos;
        int since_sof;
        int out_seg;
        int res_idx;

        always #2 clk = ~clk;

        decap_lookup u_decap_lookup (
                .clk(clk), .rst(rst),
                .ring_in_data(ring_in_data), .ring_in_sof(ring_in_sof),
                .ring_in_sos(ring_in_sos),
                .ring_out_data(ring_out_data), .ring_out_sof(ring_out_sof),
                .ring_out_sos(ring_out_sos),
                .ht_rd(ht_rd), .ht0_addr(ht0_addr), .ht1_addr(ht1_addr),
                .ht_ack(ht_ack), .ht_rdata(ht_rdata),
                .val_rd(val_rd), .val_addr(val_addr),
                .val_ack(val_ack), .val_rdata(val_rdata)
        );

        table_model u_table_model (
                .clk(clk), .rst(rst),
                .ht_rd(ht_rd), .ht0_addr(ht0_addr), .ht1_addr(ht1_addr),
                .ht_ack(ht_ack), .ht_rdata(ht_rdata),
                .val_rd(val_rd), .val_addr(val_addr),
                .val_ack(val_ack), .val_rdata(val_rdata)
        );

        // ####################
        // Reference model
        // ####################
        function automatic logic [decap_pkg::HASH_W-1:0] fold_key(input logic [127:0] k);
                logic [decap_pkg::HASH_W-1:0] h;
                h = '0;
                for (int b = 0; b < decap_pkg::KEY_W; b++)
                        h[b % decap_pkg::HASH_W] = h[b % decap_pkg::HASH_W] ^ k[b];
                return h;
        endfunction

        function automatic logic [127:0] reverse_key(input logic [127:0] k);
                logic [127:0] r;
                for (int b = 0; b < decap_pkg::KEY_W; b++)
                        r[b] = k[decap_pkg::KEY_W-1-b];
                return r;
        endfunction

        function automatic decap_pkg::result_t ref_lookup(input int idx);
                logic [decap_pkg::KEY_W-1:0] k;
                logic [decap_pkg::HASH_W-1:0] h0;
                logic [decap_pkg::HASH_W-1:0] h1;
                logic [decap_pkg::BUCKET_W-1:0] bkt;
                logic [decap_pkg::ENTRY_W-1:0] ent;
                logic [decap_pkg::VALUE_ADDR_W-1:0] a;
                decap_pkg::result_t r;
                k = keys[idx];
                h0 = fold_key(k);
                h1 = fold_key(reverse_key(k));
                r = '0;
                r.seg = decap_pkg::SEG_IDX_W'(idx % decap_pkg::SEGS_PER_FRAME);
                for (int e = 0; e < 4; e++) begin      // Highest entry index wins
                        bkt = (e < 2) ? u_table_model.ht0_mem[h0] : u_table_model.ht1_mem[h1];
                        ent = bkt[(e % 2) * decap_pkg::ENTRY_W +: decap_pkg::ENTRY_W];
                        a = ent[decap_pkg::ENTRY_W-2 -: decap_pkg::VALUE_ADDR_W];
                        if (ent[decap_pkg::ENTRY_W-1] && u_table_model.val_mem[a].key == k) begin
                                r.hit = 1'b1;
                                r.payload = u_table_model.val_mem[a].payload;
                        end
                end
                return r;
        endfunction

        // ####################
        // Failure handling and compares
        // ####################
        task automatic stop_run();
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic abort_run(input string why);
                $display("%s", why);
                stop_run();
        endtask

        task automatic check_word(input string name, input logic [decap_pkg::RING_W-1:0] got,
                        input logic [decap_pkg::RING_W-1:0] exp);
                if (got !== exp) begin
                        $display("ERR %s got %h expected %h", name, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_result(input decap_pkg::result_t got, input decap_pkg::result_t exp);
                if (got !== exp) begin
                        $write("ERR result got seg %h hit %h payload %h", got.seg, got.hit,
                                got.payload);
                        $display(" expected seg %h hit %h payload %h", exp.seg, exp.hit,
                                exp.payload);
                        stop_run();
                end
        endtask

        // ####################
        // Table setup and stimulus
        // ####################
        task automatic put_entry(input int idx, input bit tbl, input bit slot, input bit valid);
                logic [decap_pkg::VALUE_ADDR_W-1:0] a;
                logic [decap_pkg::HASH_W-1:0] h;
                logic [decap_pkg::ENTRY_W-1:0] ent;
                a = decap_pkg::VALUE_ADDR_W'(16 * idx + 5);    // Private value word per key
                h = tbl ? fold_key(reverse_key(keys[idx])) : fold_key(keys[idx]);
                ent = {valid, a, h};
                u_table_model.val_mem[a] = '{key: keys[idx], payload: 32'($random(seed)) | 32'd1};
                if (tbl)
                        u_table_model.ht1_mem[h][slot * decap_pkg::ENTRY_W +: decap_pkg::ENTRY_W] = ent;
                else
                        u_table_model.ht0_mem[h][slot * decap_pkg::ENTRY_W +: decap_pkg::ENTRY_W] = ent;
        endtask

        task automatic fill_tables();
                logic [31:0] pick;
                for (int a = 0; a < 2**decap_pkg::HASH_W; a++) begin
                        u_table_model.ht0_mem[a] = {2{1'b0, decap_pkg::VALUE_ADDR_W'(a),
                                decap_pkg::HASH_W'(a)}};
                        u_table_model.ht1_mem[a] = {2{1'b0, ~decap_pkg::VALUE_ADDR_W'(a),
                                decap_pkg::HASH_W'(a)}};
                end
                for (int a = 0; a < 2**decap_pkg::VALUE_ADDR_W; a++)
                        u_table_model.val_mem[a] = '{key: {8{4'hc, decap_pkg::VALUE_ADDR_W'(a)}},
                                payload: {20'h5a5a5, decap_pkg::VALUE_ADDR_W'(a)}};
                // Key 0 goes in last so no other key can overwrite its entry
                for (int i = NUM_KEYS - 1; i >= 0; i--) begin
                        pick = $random(seed);
                        if (i == 0 || pick[0])
                                put_entry(i, pick[1], pick[2], 1'b1);
                        else if (i % 3 == 0)
                                put_entry(i, pick[1], pick[2], 1'b0);
                end
        endtask

        task automatic drive_word(input logic [63:0] data, input bit sof, input bit sos);
                @(posedge clk);
                #1;
                ring_in_data = data;
                ring_in_sof = sof;
                ring_in_sos = sos;
        endtask

        initial begin
                logic [63:0] data;
                clk = 1'b0;
                rst = 1'b1;
                ring_in_data = '0;
                ring_in_sof = 1'b0;
                ring_in_sos = 1'b0;
                seed = 32'h4e17_8730;
                warmup = 1'b1;
                for (int i = 0; i < NUM_KEYS; i++)
                        keys[i] = {32'($random(seed)), 32'($random(seed)),
                                32'($random(seed)), 32'($random(seed))};
                fill_tables();
                repeat (3) @(posedge clk);
                #1;
                rst = 1'b0;
                for (int f = 0; f < decap_pkg::WARMUP_FRAMES + 4; f++) begin
                        if (f == decap_pkg::WARMUP_FRAMES)
                                warmup = 1'b0;
                        for (int s = 0; s < decap_pkg::SEGS_PER_FRAME; s++) begin
                                for (int w = 0; w < SEG_CYC; w++) begin
                                        data = {32'($random(seed)), 32'($random(seed))};
                                        if (f >= decap_pkg::WARMUP_FRAMES && w < 2)
                                                data = keys[(f - decap_pkg::WARMUP_FRAMES) *
                                                        decap_pkg::SEGS_PER_FRAME + s][w*64 +: 64];
                                        drive_word(data, s == 0 && w == 0, w == 0);
                                end
                        end
                end
                forever begin          // Idle ring keeps its framing
                        for (int s = 0; s < decap_pkg::SEGS_PER_FRAME; s++)
                                for (int w = 0; w < SEG_CYC; w++)
                                        drive_word('0, s == 0 && w == 0, w == 0);
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == TIMEOUT_CYC)
                        abort_run("Timeout before all results arrived on the output ring");
        end

        // ####################
        // Output monitor
        // ####################
        initial begin
                cycles = 0;
                last_ht = -100;
                since_sos = 0;
                since_sof = 0;
                out_seg = 0;
                res_idx = 0;
                seen_sos = 1'b0;
                seen_sof = 1'b0;
                started = 1'b0;
        end

        always @(negedge clk) begin
                decap_pkg::result_t exp;
                decap_pkg::result_t got;
                if (!rst) begin
                        if (ht_rd) begin
                                if (warmup)
                                        abort_run("Hash-table read issued during warm-up frames");
                                if (cycles - last_ht < decap_pkg::PROBE_GAP)
                                        abort_run("Hash-table reads closer than the probe gap");
                                last_ht = cycles;
                        end
                        if (ring_out_sof) begin
                                if (!ring_out_sos)
                                        abort_run("Output sof without sos");
                                if (seen_sof && since_sof != FRAME_CYC - 1)
                                        abort_run("Output sof period is wrong");
                                since_sof = 0;
                                seen_sof = 1'b1;
                        end else begin
                                since_sof++;
                        end
                        if (ring_out_sos) begin
                                if (seen_sos && since_sos != SEG_CYC - 1)
                                        abort_run("Output sos period is wrong");
                                since_sos = 0;
                                seen_sos = 1'b1;
                                out_seg = ring_out_sof ? 0 :
                                        (out_seg + 1) % decap_pkg::SEGS_PER_FRAME;  // Next segment
                        end else begin
                                since_sos++;
                        end
                        if (seen_sos && since_sos == 1) begin  // Word 0 follows sos
                                if (!started && ring_out_data != '0)
                                        started = 1'b1;
                                if (started) begin
                                        exp = ref_lookup(res_idx);
                                        got.hit = ring_out_data[63];
                                        got.seg = decap_pkg::SEG_IDX_W'(out_seg);
                                        got.payload = ring_out_data[31:0];
                                        check_result(got, exp);
                                        check_word("ring_out_data", ring_out_data,
                                                {exp.hit, 31'b0, exp.payload});
                                        res_idx++;
                                        if (res_idx == NUM_KEYS) begin
                                                $display("Simulation passed");
                                                $finish;
                                        end
                                end
                        end else begin
                                check_word("ring_out_data", ring_out_data, '0);
                        end
                end
        end

endmodule

`default_nettype wire

//--- verilog.f
common/decap_pkg.sv
design/sync_fifo.sv
design/ring_capture.sv
lookup/key_hash.sv
lookup/bucket_probe.sv
lookup/entry_match.sv
design/ring_emit.sv
design/decap_lookup.sv
sim/table_model.sv
sim/decap_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module decap_tb -o decap_sim
./obj_dir/decap_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
        exit 0
else
        exit 1
fi
